//--- design/biu_pkg.sv
`default_nettype none

package biu_pkg;

  ////////////////////////////////////////////////////////////////////
  // Access sizes
  ////////////////////////////////////////////////////////////////////

  // Log2 of the byte count
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

  ////////////////////////////////////////////////////////////////////
  // Region configuration word
  ////////////////////////////////////////////////////////////////////

  // Layout {type[13:12], flags[11:4], amo[3:2], mode[1:0]}
  localparam int PMA_CFG_W = 14;

  // Memory type field
  localparam int PMA_TYPE_LSB = 12;
  // Access flags with bit 9 as EXEC and the rest reserved
  localparam int PMA_R_BIT = 11;
  localparam int PMA_W_BIT = 10;
  // Atomics field where only "none" is served
  localparam int PMA_AMO_LSB = 2;
  // Address match mode
  localparam int PMA_MODE_LSB = 0;

  // Match modes as in the RISC-V pmpcfg A field
  localparam logic [1:0] MATCH_OFF   = 2'd0;
  localparam logic [1:0] MATCH_TOR   = 2'd1;
  localparam logic [1:0] MATCH_NA4   = 2'd2;
  localparam logic [1:0] MATCH_NAPOT = 2'd3;

  // Memory types
  localparam logic [1:0] MEM_TYPE_EMPTY = 2'd0;
  localparam logic [1:0] MEM_TYPE_MAIN  = 2'd1;
  localparam logic [1:0] MEM_TYPE_IO    = 2'd2;

  ////////////////////////////////////////////////////////////////////
  // Memory mapped catchers
  ////////////////////////////////////////////////////////////////////

  localparam logic [31:0] TOHOST_ADDR  = 32'h0000_1000;
  localparam logic [31:0] UART_TX_ADDR = 32'h0000_1080;

endpackage

`default_nettype wire

//--- design/biu_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module biu_subsystem #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int PMA_CNT     = 4,
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_LATENCY = 1,
  parameter int MEM_WORDS   = 256
) (
  input  wire                                     HCLK,
  input  wire                                     arst_n_i,
  // Request strobe side
  input  wire                                     req_stb_i,
  input  wire                                     req_we_i,
  input  wire  [2:0]                              req_size_i,
  input  wire  [PLEN-1:0]                         req_adr_i,
  input  wire  [XLEN-1:0]                         req_d_i,
  // Region setup, held steady
  input  wire  [PMA_CNT*biu_pkg::PMA_CFG_W-1:0]   pma_cfg_i,
  input  wire  [PMA_CNT*PLEN-1:0]                 pma_adr_i,
  // Responses and catchers
  output logic                                    rsp_ack_o,
  output logic                                    rsp_err_o,
  output logic [XLEN-1:0]                         rsp_q_o,
  output logic                                    overflow_o,
  output logic                                    tohost_stb_o,
  output logic [XLEN-1:0]                         tohost_o,
  output logic                                    uart_stb_o,
  output logic [7:0]                              uart_byte_o
);

  // Checker to queue
  logic            push;
  logic            push_we;
  logic [2:0]      push_size;
  logic [PLEN-1:0] push_adr;
  logic [XLEN-1:0] push_d;
  logic            push_fault;
  logic            full;

  // Queue to target
  logic            not_empty;
  logic            head_we;
  logic [2:0]      head_size;
  logic [PLEN-1:0] head_adr;
  logic [XLEN-1:0] head_d;
  logic            head_fault;
  logic            pop;

  pma_checker #(
    .XLEN   (XLEN),
    .PLEN   (PLEN),
    .PMA_CNT(PMA_CNT)
  ) u_pma_checker (
    .HCLK        (HCLK),
    .arst_n_i    (arst_n_i),
    .req_stb_i   (req_stb_i),
    .req_we_i    (req_we_i),
    .req_size_i  (req_size_i),
    .req_adr_i   (req_adr_i),
    .req_d_i     (req_d_i),
    .pma_cfg_i   (pma_cfg_i),
    .pma_adr_i   (pma_adr_i),
    .full_i      (full),
    .push_o      (push),
    .push_we_o   (push_we),
    .push_size_o (push_size),
    .push_adr_o  (push_adr),
    .push_d_o    (push_d),
    .push_fault_o(push_fault),
    .overflow_o  (overflow_o)
  );

  request_queue #(
    .DEPTH(QUEUE_DEPTH),
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_request_queue (
    .HCLK        (HCLK),
    .arst_n_i    (arst_n_i),
    .push_i      (push),
    .push_we_i   (push_we),
    .push_size_i (push_size),
    .push_adr_i  (push_adr),
    .push_d_i    (push_d),
    .push_fault_i(push_fault),
    .pop_i       (pop),
    .full_o      (full),
    .not_empty_o (not_empty),
    .head_we_o   (head_we),
    .head_size_o (head_size),
    .head_adr_o  (head_adr),
    .head_d_o    (head_d),
    .head_fault_o(head_fault)
  );

  mem_target #(
    .XLEN       (XLEN),
    .PLEN       (PLEN),
    .MEM_LATENCY(MEM_LATENCY),
    .MEM_WORDS  (MEM_WORDS)
  ) u_mem_target (
    .HCLK        (HCLK),
    .arst_n_i    (arst_n_i),
    .not_empty_i (not_empty),
    .head_we_i   (head_we),
    .head_size_i (head_size),
    .head_adr_i  (head_adr),
    .head_d_i    (head_d),
    .head_fault_i(head_fault),
    .pop_o       (pop),
    .rsp_ack_o   (rsp_ack_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_q_o     (rsp_q_o),
    .tohost_stb_o(tohost_stb_o),
    .tohost_o    (tohost_o),
    .uart_stb_o  (uart_stb_o),
    .uart_byte_o (uart_byte_o)
  );

endmodule

`default_nettype wire

//--- design/mem_target.sv
`timescale 1ns/1ps
`default_nettype none

module mem_target #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_LATENCY = 1,
  parameter int MEM_WORDS   = 256
) (
  input  wire              HCLK,
  input  wire              arst_n_i,
  input  wire              not_empty_i,
  input  wire              head_we_i,
  input  wire  [2:0]       head_size_i,
  input  wire  [PLEN-1:0]  head_adr_i,
  input  wire  [XLEN-1:0]  head_d_i,
  input  wire              head_fault_i,
  output logic             pop_o,
  output logic             rsp_ack_o,
  output logic             rsp_err_o,
  output logic [XLEN-1:0]  rsp_q_o,
  output logic             tohost_stb_o,
  output logic [XLEN-1:0]  tohost_o,
  output logic             uart_stb_o,
  output logic [7:0]       uart_byte_o
);

  localparam int BL = XLEN / 8;
  localparam int LW = $clog2(BL);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  logic [XLEN-1:0] ram [MEM_WORDS];

  logic            busy;
  logic [CW-1:0]   lat_cnt;
  logic            done;
  logic            ent_we;
  logic [2:0]      ent_size;
  logic [PLEN-1:0] ent_adr;
  logic [XLEN-1:0] ent_d;
  logic            ent_fault;
  logic            is_tohost;
  logic            is_uart;
  logic            ram_wr;
  logic [PLEN-1:0] widx;
  logic [BL-1:0]   be;
  logic [XLEN-1:0] rdata;

  ////////////////////////////////////////////////////////////////////
  // Entry sequencing
  ////////////////////////////////////////////////////////////////////

  // One entry in flight at a time
  assign pop_o = not_empty_i & ~busy;
  assign done  = busy & (lat_cnt == CW'(1));

  always_ff @(posedge HCLK) begin
    if (pop_o) begin
      ent_we    <= head_we_i;
      ent_size  <= head_size_i;
      ent_adr   <= head_adr_i;
      ent_d     <= head_d_i;
      ent_fault <= head_fault_i;
    end
  end

  // Address decode
  assign is_tohost = (ent_adr == PLEN'(biu_pkg::TOHOST_ADDR));
  assign is_uart   = (ent_adr == PLEN'(biu_pkg::UART_TX_ADDR));
  assign ram_wr    = done & ~ent_fault & ent_we & ~is_tohost & ~is_uart;
  assign widx      = (ent_adr >> 2) % PLEN'(MEM_WORDS);

  // Byte lanes from the low address bits
  always_comb begin
    case (ent_size)
      biu_pkg::SIZE_BYTE: be = BL'(1) << ent_adr[LW-1:0];
      biu_pkg::SIZE_HALF: be = BL'(3) << ent_adr[LW-1:0];
      default:            be = '1;
    endcase
  end

  // Lanes outside the access read as zero
  always_comb begin
    for (int l = 0; l < BL; l++) begin
      rdata[8*l +: 8] = be[l] ? ram[widx][8*l +: 8] : 8'h00;
    end
  end

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy         <= 1'b0;
      lat_cnt      <= '0;
      rsp_ack_o    <= 1'b0;
      rsp_err_o    <= 1'b0;
      tohost_stb_o <= 1'b0;
      uart_stb_o   <= 1'b0;
      tohost_o     <= '0;
    end else begin
      rsp_ack_o    <= 1'b0;
      rsp_err_o    <= 1'b0;
      tohost_stb_o <= 1'b0;
      uart_stb_o   <= 1'b0;
      if (pop_o) begin
        busy    <= 1'b1;
        lat_cnt <= CW'(MEM_LATENCY);
      end else if (busy) begin
        lat_cnt <= lat_cnt - 1'b1;
        if (done) begin
          busy      <= 1'b0;
          rsp_err_o <= ent_fault;
          rsp_ack_o <= ~ent_fault;
          // Catchers only see good writes
          if (!ent_fault && ent_we && is_tohost) begin
            tohost_stb_o <= 1'b1;
            tohost_o     <= ent_d;
          end
          uart_stb_o <= ~ent_fault & ent_we & is_uart;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////

  // Write data arrives lane aligned
  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        ram[w] <= '0;
      end
    end else if (ram_wr) begin
      for (int l = 0; l < BL; l++) begin
        if (be[l]) begin
          ram[widx][8*l +: 8] <= ent_d[8*l +: 8];
        end
      end
    end
  end

  // Zero for writes, faults and catcher reads
  always_ff @(posedge HCLK) begin
    if (done) begin
      rsp_q_o     <= (!ent_fault && !ent_we && !is_tohost && !is_uart) ? rdata : '0;
      uart_byte_o <= ent_d[7:0];
    end
  end

endmodule

`default_nettype wire

//--- design/pma_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pma_checker #(
  parameter int XLEN    = 32,
  parameter int PLEN    = 32,
  parameter int PMA_CNT = 4
) (
  input  wire                                     HCLK,
  input  wire                                     arst_n_i,
  input  wire                                     req_stb_i,
  input  wire                                     req_we_i,
  input  wire  [2:0]                              req_size_i,
  input  wire  [PLEN-1:0]                         req_adr_i,
  input  wire  [XLEN-1:0]                         req_d_i,
  input  wire  [PMA_CNT*biu_pkg::PMA_CFG_W-1:0]   pma_cfg_i,
  input  wire  [PMA_CNT*PLEN-1:0]                 pma_adr_i,
  input  wire                                     full_i,
  output logic                                    push_o,
  output logic                                    push_we_o,
  output logic [2:0]                              push_size_o,
  output logic [PLEN-1:0]                         push_adr_o,
  output logic [XLEN-1:0]                         push_d_o,
  output logic                                    push_fault_o,
  output logic                                    overflow_o
);

  logic                                          stb_q;
  logic                                          we_q;
  logic [2:0]                                    size_q;
  logic [PLEN-1:0]                               adr_q;
  logic [XLEN-1:0]                               d_q;
  logic [PLEN-1:0]                               wadr;
  logic [PMA_CNT-1:0][biu_pkg::PMA_CFG_W-1:0]    cfg_a;
  logic [PMA_CNT-1:0][PLEN-1:0]                  adr_a;
  logic [PMA_CNT-1:0]                            hit;
  logic                                          any_hit;
  logic [biu_pkg::PMA_CFG_W-1:0]                 sel_cfg;
  logic [1:0]                                    sel_type;
  logic                                          perm_ok;
  logic                                          misaligned;
  logic                                          fault;

  ////////////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stb_q      <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      stb_q      <= req_stb_i;
      // Queue full at the push edge drops the entry
      overflow_o <= stb_q & full_i;
    end
  end

  // Payload held only while a strobe is seen
  always_ff @(posedge HCLK) begin
    if (req_stb_i) begin
      we_q   <= req_we_i;
      size_q <= req_size_i;
      adr_q  <= req_adr_i;
      d_q    <= req_d_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////////////

  assign cfg_a = pma_cfg_i;
  assign adr_a = pma_adr_i;

  // Region addresses are in words
  assign wadr = {2'b00, adr_q[PLEN-1:2]};

  for (genvar i = 0; i < PMA_CNT; i++) begin : g_region
    logic [1:0]      mode;
    logic [PLEN-1:0] bot;
    logic [PLEN-1:0] mask;
    logic            tor_hit;
    logic            msk_hit;

    assign mode = cfg_a[i][biu_pkg::PMA_MODE_LSB +: 2];

    // TOR lower bound comes from the entry below
    if (i == 0) begin : g_first
      assign bot = '0;
    end else begin : g_next
      assign bot = adr_a[i-1];
    end

    // Trailing ones plus the first zero are don't care in NAPOT
    assign mask    = (mode == biu_pkg::MATCH_NA4) ? '1 : ~(adr_a[i] ^ (adr_a[i] + 1'b1));
    assign tor_hit = (wadr >= bot) && (wadr < adr_a[i]);
    assign msk_hit = ((wadr ^ adr_a[i]) & mask) == '0;

    assign hit[i] = (mode == biu_pkg::MATCH_OFF) ? 1'b0 :
                    (mode == biu_pkg::MATCH_TOR) ? tor_hit : msk_hit;
  end

  // Lowest index wins
  always_comb begin
    any_hit = 1'b0;
    sel_cfg = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (hit[i]) begin
        any_hit = 1'b1;
        sel_cfg = cfg_a[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Fault decision
  ////////////////////////////////////////////////////////////////////

  assign sel_type = sel_cfg[biu_pkg::PMA_TYPE_LSB +: 2];
  assign perm_ok  = we_q ? sel_cfg[biu_pkg::PMA_W_BIT] : sel_cfg[biu_pkg::PMA_R_BIT];

  always_comb begin
    case (size_q)
      biu_pkg::SIZE_HALF: misaligned = adr_q[0];
      biu_pkg::SIZE_WORD: misaligned = |adr_q[1:0];
      default:            misaligned = 1'b0;
    endcase
  end

  assign fault = ~any_hit | (sel_type == biu_pkg::MEM_TYPE_EMPTY) | ~perm_ok |
                 misaligned | (size_q > biu_pkg::SIZE_WORD);

  // Entry goes to the queue at the next edge
  assign push_o       = stb_q & ~full_i;
  assign push_we_o    = we_q;
  assign push_size_o  = size_q;
  assign push_adr_o   = adr_q;
  assign push_d_o     = d_q;
  assign push_fault_o = fault;

endmodule

`default_nettype wire

//--- design/request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module request_queue #(
  parameter int DEPTH = 4,
  parameter int XLEN  = 32,
  parameter int PLEN  = 32
) (
  input  wire              HCLK,
  input  wire              arst_n_i,
  input  wire              push_i,
  input  wire              push_we_i,
  input  wire  [2:0]       push_size_i,
  input  wire  [PLEN-1:0]  push_adr_i,
  input  wire  [XLEN-1:0]  push_d_i,
  input  wire              push_fault_i,
  input  wire              pop_i,
  output logic             full_o,
  output logic             not_empty_o,
  output logic             head_we_o,
  output logic [2:0]       head_size_o,
  output logic [PLEN-1:0]  head_adr_o,
  output logic [XLEN-1:0]  head_d_o,
  output logic             head_fault_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Entry storage
  logic            we_mem    [DEPTH];
  logic [2:0]      size_mem  [DEPTH];
  logic [PLEN-1:0] adr_mem   [DEPTH];
  logic [XLEN-1:0] d_mem     [DEPTH];
  logic            fault_mem [DEPTH];

  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  // A pop in the same cycle frees a slot
  assign full_o      = (count == CW'(DEPTH)) & ~pop_i;
  assign not_empty_o = (count != '0);
  assign do_push     = push_i & ~full_o;
  assign do_pop      = pop_i & not_empty_o;

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (do_push) begin
      we_mem[wr_ptr]    <= push_we_i;
      size_mem[wr_ptr]  <= push_size_i;
      adr_mem[wr_ptr]   <= push_adr_i;
      d_mem[wr_ptr]     <= push_d_i;
      fault_mem[wr_ptr] <= push_fault_i;
    end
  end

  // First word fall through
  assign head_we_o    = we_mem[rd_ptr];
  assign head_size_o  = size_mem[rd_ptr];
  assign head_adr_o   = adr_mem[rd_ptr];
  assign head_d_o     = d_mem[rd_ptr];
  assign head_fault_o = fault_mem[rd_ptr];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from its log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module biu_tb -Mdir obj_dir
./obj_dir/Vbiu_tb | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "Run result: PASS"
else
  echo "Run result: FAIL"
  exit 1
fi

//--- testbench/biu_cases.hex
// kind_we_size_address_wdata_experr_expdata, kind 0 request, 1 burst, 2 no gap
// expdata is lane aligned read data, zero for writes and errors
0_1_2_00000010_11223344_0_00000000
0_1_1_00000012_AABB0000_0_00000000
0_1_0_00000011_0000CC00_0_00000000
0_1_0_00000020_000000EE_0_00000000
0_1_0_00000023_5A000000_0_00000000
0_0_2_00000010_00000000_0_AABBCC44
0_0_2_00000020_00000000_0_5A0000EE
0_0_1_00000012_00000000_0_AABB0000
0_0_0_00000011_00000000_0_0000CC00
0_0_2_00000012_00000000_1_00000000
2_0_2_00000020_00000000_0_5A0000EE
2_1_1_00000013_0000FFFF_1_00000000
2_0_2_00001040_00000000_1_00000000
2_0_2_00001F00_00000000_0_00000000
2_1_2_00001100_12345678_1_00000000
0_1_2_00001000_CAFE0001_0_00000000
0_1_2_00001080_00000A41_0_00000000
0_0_2_00001000_00000000_1_00000000
0_1_2_00001004_00000000_1_00000000
0_0_3_00000000_00000000_1_00000000
0_0_2_00003000_00000000_1_00000000
1_1_2_00000200_A5A50000_0_00000000
0_0_2_00000010_00000000_0_AABBCC44
0_0_2_00000020_00000000_0_5A0000EE

//--- testbench/biu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module biu_tb;

  localparam int XLEN        = 32;
  localparam int PLEN        = 32;
  localparam int PMA_CNT     = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int MEM_LATENCY = 1;
  localparam int MEM_WORDS   = 256;
  localparam int CFG_W       = biu_pkg::PMA_CFG_W;
  localparam int MAX_CASES   = 64;

  logic                     HCLK;
  logic                     arst_n;
  logic                     req_stb;
  logic                     req_we;
  logic [2:0]               req_size;
  logic [PLEN-1:0]          req_adr;
  logic [XLEN-1:0]          req_d;
  logic [PMA_CNT*CFG_W-1:0] pma_cfg;
  logic [PMA_CNT*PLEN-1:0]  pma_adr;
  logic                     rsp_ack;
  logic                     rsp_err;
  logic [XLEN-1:0]          rsp_q;
  logic                     overflow;
  logic                     tohost_stb;
  logic [XLEN-1:0]          tohost;
  logic                     uart_stb;
  logic [7:0]               uart_byte;

  // Case word {kind, we, size, adr, wdata, err, rdata}
  logic [111:0]    cases_mem [MAX_CASES];
  // Outstanding responses as {burst, err, rdata}
  logic [33:0]     pend_q    [$];
  logic [XLEN-1:0] tohost_q  [$];
  logic [7:0]      uart_q    [$];

  int   n_cases;
  int   err_cnt;
  int   sent_cnt;
  int   rsp_cnt;
  int   ovf_cnt;
  int   seed = 32'hf62b_c750;
  logic burst_sent;

  biu_subsystem #(
    .XLEN       (XLEN),
    .PLEN       (PLEN),
    .PMA_CNT    (PMA_CNT),
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .MEM_LATENCY(MEM_LATENCY),
    .MEM_WORDS  (MEM_WORDS)
  ) dut_i (
    .HCLK        (HCLK),
    .arst_n_i    (arst_n),
    .req_stb_i   (req_stb),
    .req_we_i    (req_we),
    .req_size_i  (req_size),
    .req_adr_i   (req_adr),
    .req_d_i     (req_d),
    .pma_cfg_i   (pma_cfg),
    .pma_adr_i   (pma_adr),
    .rsp_ack_o   (rsp_ack),
    .rsp_err_o   (rsp_err),
    .rsp_q_o     (rsp_q),
    .overflow_o  (overflow),
    .tohost_stb_o(tohost_stb),
    .tohost_o    (tohost),
    .uart_stb_o  (uart_stb),
    .uart_byte_o (uart_byte)
  );

  // 4 ns clock
  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [CFG_W-1:0] region_cfg(input logic [1:0] mtype, input logic r,
                                                  input logic w, input logic [1:0] mode);
    logic [CFG_W-1:0] cfg;
    cfg = '0;
    cfg[biu_pkg::PMA_TYPE_LSB +: 2] = mtype;
    cfg[biu_pkg::PMA_R_BIT]         = r;
    cfg[biu_pkg::PMA_W_BIT]         = w;
    // AMO stays none
    cfg[biu_pkg::PMA_MODE_LSB +: 2] = mode;
    return cfg;
  endfunction

  // One strobe, held for exactly one sampling edge
  task automatic issue_request(input logic we, input logic [2:0] size, input logic [31:0] adr,
                               input logic [31:0] wdata, input logic burst,
                               input logic want_err, input logic [31:0] want_q);
    req_stb  = 1'b1;
    req_we   = we;
    req_size = size;
    req_adr  = adr;
    req_d    = wdata;
    pend_q.push_back({burst, want_err, want_q});
    // Catchers only see accepted writes
    if (!want_err && we && adr == biu_pkg::TOHOST_ADDR) begin
      tohost_q.push_back(wdata);
    end
    if (!want_err && we && adr == biu_pkg::UART_TX_ADDR) begin
      uart_q.push_back(wdata[7:0]);
    end
    sent_cnt++;
    @(posedge HCLK);
    #1;
    req_stb = 1'b0;
  endtask

  task automatic wait_drained();
    while (pend_q.size() != 0) begin
      @(posedge HCLK);
      #1;
    end
  endtask

  task automatic check_response();
    logic [33:0] want;
    rsp_cnt++;
    if (rsp_ack && rsp_err) begin
      $display("Error: ack and err raised together at %0t", $time);
      err_cnt++;
    end
    if (pend_q.size() == 0) begin
      $display("Error: response at %0t with no request outstanding", $time);
      err_cnt++;
    end else begin
      want = pend_q.pop_front();
      if (rsp_err != want[32]) begin
        $display("[FAIL] rsp_err_o got %h expected %h at %0t", rsp_err, want[32], $time);
        err_cnt++;
      end else if (rsp_ack && rsp_q != want[31:0]) begin
        $display("[FAIL] rsp_q_o got %h expected %h at %0t", rsp_q, want[31:0], $time);
        err_cnt++;
      end
    end
  endtask

  // Dropped burst writes all expect the same ack, so the newest one goes
  task automatic note_overflow();
    logic [33:0] last;
    ovf_cnt++;
    if (pend_q.size() == 0) begin
      $display("Error: overflow pulse at %0t with nothing outstanding", $time);
      err_cnt++;
    end else begin
      last = pend_q[pend_q.size() - 1];
      if (last[33]) begin
        last = pend_q.pop_back();
      end else begin
        $display("Error: overflow pulse at %0t outside a burst", $time);
        err_cnt++;
      end
    end
  endtask

  task automatic check_catchers();
    logic [XLEN-1:0] want_word;
    logic [7:0]      want_byte;
    if (tohost_stb) begin
      if (tohost_q.size() == 0) begin
        $display("Error: unexpected tohost strobe at %0t", $time);
        err_cnt++;
      end else begin
        want_word = tohost_q.pop_front();
        if (tohost != want_word) begin
          $display("[FAIL] tohost_o got %h expected %h", tohost, want_word);
          err_cnt++;
        end
      end
    end
    if (uart_stb) begin
      if (uart_q.size() == 0) begin
        $display("Error: unexpected UART strobe at %0t", $time);
        err_cnt++;
      end else begin
        want_byte = uart_q.pop_front();
        if (uart_byte != want_byte) begin
          $display("[FAIL] uart_byte_o got %h expected %h", uart_byte, want_byte);
          err_cnt++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor sampling mid cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge HCLK) begin
    if (arst_n) begin
      if (rsp_ack || rsp_err) begin
        check_response();
      end
      if (overflow) begin
        note_overflow();
      end
      check_catchers();
    end
  end

  // Watchdog scaled by the case count
  initial begin
    int limit;
    #1;
    limit = n_cases * (MEM_LATENCY + 8) + 200;
    repeat (limit) @(posedge HCLK);
    $display("Error: watchdog expired after %0d cycles", limit);
    $display("Errors: %0d, sent: %0d, responses: %0d, overflows: %0d",
             err_cnt + 1, sent_cnt, rsp_cnt, ovf_cnt);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [111:0] cur;
    logic [3:0]   kind;
    int           gap;
    // Kind F marks an unused slot
    for (int i = 0; i < MAX_CASES; i++) begin
      cases_mem[i] = '1;
    end
    $readmemh("testbench/biu_cases.hex", cases_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && cases_mem[n_cases][111:108] != 4'hF) begin
      n_cases++;
    end
    err_cnt    = 0;
    sent_cnt   = 0;
    rsp_cnt    = 0;
    ovf_cnt    = 0;
    burst_sent = 1'b0;
    arst_n     = 1'b0;
    req_stb    = 1'b0;
    req_we     = 1'b0;
    req_size   = '0;
    req_adr    = '0;
    req_d      = '0;
    // Regions 0 and 3 are RAM and regions 1 and 2 are the catchers
    pma_cfg[0*CFG_W +: CFG_W] = region_cfg(biu_pkg::MEM_TYPE_MAIN, 1'b1, 1'b1,
                                           biu_pkg::MATCH_TOR);
    pma_cfg[1*CFG_W +: CFG_W] = region_cfg(biu_pkg::MEM_TYPE_IO, 1'b0, 1'b1,
                                           biu_pkg::MATCH_NA4);
    pma_cfg[2*CFG_W +: CFG_W] = region_cfg(biu_pkg::MEM_TYPE_IO, 1'b0, 1'b1,
                                           biu_pkg::MATCH_NA4);
    pma_cfg[3*CFG_W +: CFG_W] = region_cfg(biu_pkg::MEM_TYPE_MAIN, 1'b1, 1'b0,
                                           biu_pkg::MATCH_TOR);
    pma_adr[0*PLEN +: PLEN] = biu_pkg::TOHOST_ADDR >> 2;
    pma_adr[1*PLEN +: PLEN] = biu_pkg::TOHOST_ADDR >> 2;
    // Also the TOR base of region 3 while the UART word itself hits region 2
    pma_adr[2*PLEN +: PLEN] = biu_pkg::UART_TX_ADDR >> 2;
    pma_adr[3*PLEN +: PLEN] = 32'h0000_2000 >> 2;

    repeat (3) @(posedge HCLK);
    #1;
    arst_n = 1'b1;
    @(posedge HCLK);
    #1;

    for (int idx = 0; idx < n_cases; idx++) begin
      cur  = cases_mem[idx];
      kind = cur[111:108];
      if (kind == 4'h1) begin
        // Starts right behind the previous request so the queue fills
        burst_sent = 1'b1;
        for (int i = 0; i < QUEUE_DEPTH + 4; i++) begin
          issue_request(cur[104], cur[102:100], cur[99:68] + 32'(4 * i),
                        cur[67:36] + 32'(i), 1'b1, 1'b0, '0);
        end
      end else begin
        // Kind 2 follows with no gap
        if (kind == 4'h0) begin
          wait_drained();
          gap = $random(seed) & 3;
          repeat (gap) begin
            @(posedge HCLK);
            #1;
          end
        end
        issue_request(cur[104], cur[102:100], cur[99:68], cur[67:36], 1'b0,
                      cur[32], cur[31:0]);
      end
    end

    wait_drained();
    // Room for stray pulses
    repeat (10) @(posedge HCLK);
    #1;
    if (tohost_q.size() != 0 || uart_q.size() != 0) begin
      $display("Error: %0d tohost and %0d UART strobes never came",
               tohost_q.size(), uart_q.size());
      err_cnt++;
    end
    if (sent_cnt != rsp_cnt + ovf_cnt) begin
      $display("Error: %0d requests sent but %0d responses and %0d overflows seen",
               sent_cnt, rsp_cnt, ovf_cnt);
      err_cnt++;
    end
    if (burst_sent && ovf_cnt == 0) begin
      $display("Error: burst filled the queue without any overflow pulse");
      err_cnt++;
    end
    $display("Errors: %0d, sent: %0d, responses: %0d, overflows: %0d",
             err_cnt, sent_cnt, rsp_cnt, ovf_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/biu_pkg.sv
design/pma_checker.sv
design/request_queue.sv
design/mem_target.sv
design/biu_subsystem.sv
testbench/biu_tb.sv
